/* include/tmu_params.svh */
`ifndef TMU_PARAMS_SVH
`define TMU_PARAMS_SVH

// ----------------------------------------
// egress slice geometry
// ----------------------------------------
`define TMU_PORTS   4
`define TMU_TCS     2
// one voq per port and traffic class
`define TMU_QUEUES  (`TMU_PORTS * `TMU_TCS)
`define TMU_QDEPTH  16

// ----------------------------------------
// tag field and counter widths
// ----------------------------------------
`define TMU_PTR_W   12
`define TMU_SEG_W   5
// 64B segments, longest legal packet
`define TMU_MAX_SEG 24
`define TMU_CNT_W   9
`define TMU_CREDITS 4
`define TMU_ERR_W   16

`endif

/* verilog/tmu_pkg.sv */
`default_nettype none

`include "tmu_params.svh"

package tmu_pkg;

    // ----------------------------------------
    // tag ring fields
    // ----------------------------------------
    // egress port number
    typedef logic [$clog2(`TMU_PORTS)-1:0] port_t;
    // traffic class within a port
    typedef logic [$clog2(`TMU_TCS)-1:0] tc_t;
    // voq index, port * tcs + tc
    typedef logic [$clog2(`TMU_QUEUES)-1:0] qid_t;
    // packet buffer pointer
    typedef logic [`TMU_PTR_W-1:0] buf_ptr_t;
    // length in 64B segments
    typedef logic [`TMU_SEG_W-1:0] seg_len_t;

    // ----------------------------------------
    // accounting
    // ----------------------------------------
    // per queue segment total, holds qdepth * max_seg
    typedef logic [`TMU_CNT_W-1:0] seg_cnt_t;
    // drop and bad tag counters
    typedef logic [`TMU_ERR_W-1:0] err_cnt_t;
    // read request credits, 0 up to credits
    typedef logic [$clog2(`TMU_CREDITS + 1)-1:0] credit_t;

endpackage : tmu_pkg

`default_nettype wire

/* verilog/tmu_enq_if.sv */
`default_nettype none

// decoded tag from the collator into the queue bank
interface tmu_enq_if;
    import tmu_pkg::*;

    // one cycle transfer, no back-pressure
    logic     valid;
    qid_t     qid;
    buf_ptr_t ptr;
    seg_len_t len;

    modport collator (output valid, qid, ptr, len);

    modport bank (input valid, qid, ptr, len);

endinterface : tmu_enq_if

`default_nettype wire

/* verilog/tmu_pop_if.sv */
`default_nettype none

// scheduler pop in, popped head tag out
interface tmu_pop_if;
    import tmu_pkg::*;

    logic     pop;
    qid_t     pop_qid;
    // head tag, one cycle after the pop
    logic     tag_valid;
    qid_t     tag_qid;
    buf_ptr_t tag_ptr;
    seg_len_t tag_len;

    modport bank (input pop, pop_qid, output tag_valid, tag_qid, tag_ptr, tag_len);

    modport requester (input pop, pop_qid, tag_valid, tag_qid, tag_ptr, tag_len);

endinterface : tmu_pop_if

`default_nettype wire

/* verilog/tag_collate.sv */
`default_nettype none

`include "tmu_params.svh"

module tag_collate (
    input  logic              clk,
    input  logic              rst_n,

    // tag ring, one tag per cycle at most
    input  logic              ring_valid,
    input  tmu_pkg::port_t    ring_port,
    input  tmu_pkg::tc_t      ring_tc,
    input  tmu_pkg::buf_ptr_t ring_ptr,
    input  tmu_pkg::seg_len_t ring_len,

    // decoded tags toward the queue bank
    tmu_enq_if.collator       enq,

    output tmu_pkg::err_cnt_t bad_tag_count
);
    import tmu_pkg::*;

    logic bad_len;
    logic tag_ok;
    qid_t ring_qid;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    // zero length or past the segment limit
    assign bad_len = (ring_len == '0) || (ring_len > seg_len_t'(`TMU_MAX_SEG));
    assign tag_ok  = ring_valid && !bad_len;

    // voq layout is port major
    assign ring_qid = qid_t'(int'(ring_port) * `TMU_TCS + int'(ring_tc));

    // ----------------------------------------
    // tag register onto enq interface
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq.valid <= 1'b0;
        end else begin
            // malformed tags stop here
            enq.valid <= tag_ok;
        end
    end

    // payload only, qualified by enq.valid
    always_ff @(posedge clk) begin
        if (tag_ok) begin
            enq.qid <= ring_qid;
            enq.ptr <= ring_ptr;
            enq.len <= ring_len;
        end
    end

    // ----------------------------------------
    // bad tag counter
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bad_tag_count <= '0;
        end else if (ring_valid && bad_len && (bad_tag_count != '1)) begin
            // saturates at all ones
            bad_tag_count <= bad_tag_count + 1'b1;
        end
    end

endmodule : tag_collate

`default_nettype wire

/* verilog/tag_queue_bank.sv */
`default_nettype none

`include "tmu_params.svh"

module tag_queue_bank (
    input  logic                                  clk,
    input  logic                                  rst_n,

    tmu_enq_if.bank                               enq,
    tmu_pop_if.bank                               pq,

    // scheduler view
    output logic [`TMU_QUEUES-1:0]                queue_valid,
    output tmu_pkg::seg_cnt_t [`TMU_QUEUES-1:0]   queue_segs,

    output tmu_pkg::err_cnt_t                     drop_count
);
    import tmu_pkg::*;

    localparam int QUEUES = `TMU_QUEUES;
    localparam int DEPTH  = `TMU_QDEPTH;
    localparam int IDX_W  = $clog2(DEPTH);
    // one more bit so a full queue is representable
    localparam int OCC_W  = $clog2(DEPTH + 1);

    // ----------------------------------------
    // storage and per queue state
    // ----------------------------------------
    buf_ptr_t         mem_ptr [QUEUES][DEPTH];
    seg_len_t         mem_len [QUEUES][DEPTH];
    logic [IDX_W-1:0] head    [QUEUES];
    logic [IDX_W-1:0] tail    [QUEUES];
    logic [OCC_W-1:0] occ     [QUEUES];

    buf_ptr_t          head_ptr;
    seg_len_t          head_len;
    logic              pop_same_q;
    logic              enq_accept;
    logic              enq_drop;
    logic [QUEUES-1:0] enq_hit;
    logic [QUEUES-1:0] pop_hit;
    seg_cnt_t          enq_segs;
    seg_cnt_t          pop_segs;

    // head of the queue being popped
    assign head_ptr = mem_ptr[pq.pop_qid][head[pq.pop_qid]];
    assign head_len = mem_len[pq.pop_qid][head[pq.pop_qid]];

    // a pop on the same queue frees the slot at this edge
    assign pop_same_q = pq.pop && (pq.pop_qid == enq.qid);
    assign enq_accept = enq.valid && ((occ[enq.qid] != OCC_W'(DEPTH)) || pop_same_q);
    assign enq_drop   = enq.valid && !enq_accept;

    assign enq_segs = seg_cnt_t'(enq.len);
    assign pop_segs = seg_cnt_t'(head_len);

    // one hot per queue strobes
    always_comb begin
        for (int q = 0; q < QUEUES; q++) begin
            enq_hit[q]     = enq_accept && (enq.qid == qid_t'(q));
            pop_hit[q]     = pq.pop && (pq.pop_qid == qid_t'(q));
            queue_valid[q] = (occ[q] != '0);
        end
    end

    // ----------------------------------------
    // pointers, occupancy, segment totals
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < QUEUES; q++) begin
                head[q]       <= '0;
                tail[q]       <= '0;
                occ[q]        <= '0;
                queue_segs[q] <= '0;
            end
        end else begin
            for (int q = 0; q < QUEUES; q++) begin
                // depth is a power of two, pointers just wrap
                head[q] <= head[q] + IDX_W'(pop_hit[q]);
                tail[q] <= tail[q] + IDX_W'(enq_hit[q]);
                // enq and pop together leave occ unchanged
                occ[q]  <= occ[q] + OCC_W'(enq_hit[q]) - OCC_W'(pop_hit[q]);
                queue_segs[q] <= queue_segs[q]
                               + (enq_hit[q] ? enq_segs : '0)
                               - (pop_hit[q] ? pop_segs : '0);
            end
        end
    end

    // tag write at the tail
    always_ff @(posedge clk) begin
        if (enq_accept) begin
            mem_ptr[enq.qid][tail[enq.qid]] <= enq.ptr;
            mem_len[enq.qid][tail[enq.qid]] <= enq.len;
        end
    end

    // ----------------------------------------
    // popped head tag toward the requester
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pq.tag_valid <= 1'b0;
        end else begin
            pq.tag_valid <= pq.pop;
        end
    end

    // read before a same edge write to a full queue
    always_ff @(posedge clk) begin
        if (pq.pop) begin
            pq.tag_qid <= pq.pop_qid;
            pq.tag_ptr <= head_ptr;
            pq.tag_len <= head_len;
        end
    end

    // drop counter, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (enq_drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // scheduler only pops a queue it sees as valid
    a_pop_not_empty : assert property (@(posedge clk) disable iff (!rst_n)
        pq.pop |-> queue_valid[pq.pop_qid]);

    for (genvar gq = 0; gq < QUEUES; gq++) begin : g_occ_chk
        a_occ_bound : assert property (@(posedge clk) disable iff (!rst_n)
            occ[gq] <= OCC_W'(DEPTH));
    end

endmodule : tag_queue_bank

`default_nettype wire

/* verilog/read_requester.sv */
`default_nettype none

`include "tmu_params.svh"

module read_requester (
    input  logic              clk,
    input  logic              rst_n,

    tmu_pop_if.requester      pq,

    // credit return from the memory read side
    input  logic              rrq_credit,
    output logic              pop_ready,

    // memory read request
    output logic              rrq_valid,
    output tmu_pkg::qid_t     rrq_qid,
    output tmu_pkg::buf_ptr_t rrq_ptr,
    output tmu_pkg::seg_len_t rrq_len
);
    import tmu_pkg::*;

    localparam credit_t MAX_CREDITS = credit_t'(`TMU_CREDITS);

    credit_t credits;

    // ----------------------------------------
    // credit counter
    // ----------------------------------------
    // the pop cycle reserves the credit, not the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= MAX_CREDITS;
        end else begin
            // pop and return in one cycle cancel out
            credits <= credits + credit_t'(rrq_credit) - credit_t'(pq.pop);
        end
    end

    // scheduler may pop while any credit is left
    assign pop_ready = (credits != '0);

    // ----------------------------------------
    // issue stage
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rrq_valid <= 1'b0;
        end else begin
            rrq_valid <= pq.tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pq.tag_valid) begin
            rrq_qid <= pq.tag_qid;
            rrq_ptr <= pq.tag_ptr;
            rrq_len <= pq.tag_len;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // scheduler honours pop_ready
    a_pop_with_credit : assert property (@(posedge clk) disable iff (!rst_n)
        pq.pop |-> (credits != '0));

    // memory side never returns more than it was given
    a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
        credits <= MAX_CREDITS);

endmodule : read_requester

`default_nettype wire

/* verilog/tmu.sv */
`default_nettype none

`include "tmu_params.svh"

module tmu (
    input  logic                                clk,
    input  logic                                rst_n,

    // tag ring input
    input  logic                                ring_valid,
    input  tmu_pkg::port_t                      ring_port,
    input  tmu_pkg::tc_t                        ring_tc,
    input  tmu_pkg::buf_ptr_t                   ring_ptr,
    input  tmu_pkg::seg_len_t                   ring_len,

    // egress scheduler
    output logic [`TMU_QUEUES-1:0]              queue_valid,
    output tmu_pkg::seg_cnt_t [`TMU_QUEUES-1:0] queue_segs,
    input  logic                                pop,
    input  tmu_pkg::qid_t                       pop_qid,
    output logic                                pop_ready,

    // memory read interface
    output logic                                rrq_valid,
    output tmu_pkg::qid_t                       rrq_qid,
    output tmu_pkg::buf_ptr_t                   rrq_ptr,
    output tmu_pkg::seg_len_t                   rrq_len,
    input  logic                                rrq_credit,

    // status
    output tmu_pkg::err_cnt_t                   bad_tag_count,
    output tmu_pkg::err_cnt_t                   drop_count
);

    tmu_enq_if enq_if ();
    tmu_pop_if pop_if ();

    // scheduler pop fans out to bank and requester
    assign pop_if.pop     = pop;
    assign pop_if.pop_qid = pop_qid;

    // ----------------------------------------
    // ring tag decode
    // ----------------------------------------
    tag_collate u_collate (
        .clk           (clk),
        .rst_n         (rst_n),
        .ring_valid    (ring_valid),
        .ring_port     (ring_port),
        .ring_tc       (ring_tc),
        .ring_ptr      (ring_ptr),
        .ring_len      (ring_len),
        .enq           (enq_if.collator),
        .bad_tag_count (bad_tag_count)
    );

    // voq storage
    tag_queue_bank u_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq         (enq_if.bank),
        .pq          (pop_if.bank),
        .queue_valid (queue_valid),
        .queue_segs  (queue_segs),
        .drop_count  (drop_count)
    );

    // credits and read request issue
    read_requester u_requester (
        .clk        (clk),
        .rst_n      (rst_n),
        .pq         (pop_if.requester),
        .rrq_credit (rrq_credit),
        .pop_ready  (pop_ready),
        .rrq_valid  (rrq_valid),
        .rrq_qid    (rrq_qid),
        .rrq_ptr    (rrq_ptr),
        .rrq_len    (rrq_len)
    );

endmodule : tmu

`default_nettype wire

/* tests/tb_tmu.sv */
`default_nettype none

`include "tmu_params.svh"

module tb_tmu;
    timeunit 1ns;
    timeprecision 1ps;
    import tmu_pkg::*;

    localparam int QUEUES  = `TMU_QUEUES;
    localparam int DEPTH   = `TMU_QDEPTH;
    localparam int CREDITS = `TMU_CREDITS;
    // tags sent past a full queue
    localparam int EXTRA   = 5;
    localparam int MIXED   = 200;
    localparam int STIM_CYCLES = 6 * QUEUES + MIXED + DEPTH + CREDITS + EXTRA + 16 * 4;

    typedef struct packed {
        logic     valid;
        qid_t     qid;
        buf_ptr_t ptr;
        seg_len_t len;
    } tag_t;

    logic                  clk;
    logic                  rst_n      = 1'b0;
    logic                  ring_valid = 1'b0;
    port_t                 ring_port  = '0;
    tc_t                   ring_tc    = '0;
    buf_ptr_t              ring_ptr   = '0;
    seg_len_t              ring_len   = '0;
    logic                  pop        = 1'b0;
    qid_t                  pop_qid    = '0;
    logic                  rrq_credit = 1'b0;
    logic [QUEUES-1:0]     queue_valid;
    seg_cnt_t [QUEUES-1:0] queue_segs;
    logic                  pop_ready;
    logic                  rrq_valid;
    qid_t                  rrq_qid;
    buf_ptr_t              rrq_ptr;
    seg_len_t              rrq_len;
    err_cnt_t              bad_tag_count;
    err_cnt_t              drop_count;

    integer seed        = 33;
    string  test_name   = "reset";
    bit     credit_hold = 1'b0;
    int     rrq_seen    = 0;

    // ----------------------------------------
    // reference model, state after last edge
    // ----------------------------------------
    tag_t     model_q [QUEUES][$];
    seg_cnt_t m_segs  [QUEUES];
    tag_t     m_enq;
    tag_t     m_tag;
    tag_t     m_rrq;
    err_cnt_t m_drops;
    err_cnt_t m_bad;
    int       m_credits;
    // requests issued, credit not yet back
    int       unreturned;

    tmu dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string what, longint exp, longint act);
        abort_run($sformatf("Error: test %s, %s expected %0d actual %0d",
                            test_name, what, exp, act));
    endtask

    task automatic check_qid(string what, qid_t exp, qid_t act);
        if (act !== exp) report_mismatch(what, exp, act);
    endtask

    task automatic check_ptr(string what, buf_ptr_t exp, buf_ptr_t act);
        if (act !== exp) report_mismatch(what, exp, act);
    endtask

    task automatic check_len(string what, seg_len_t exp, seg_len_t act);
        if (act !== exp) report_mismatch(what, exp, act);
    endtask

    task automatic check_segs(string what, seg_cnt_t exp, seg_cnt_t act);
        if (act !== exp) report_mismatch(what, exp, act);
    endtask

    task automatic check_count(string what, err_cnt_t exp, err_cnt_t act);
        if (act !== exp) report_mismatch(what, exp, act);
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) report_mismatch(what, exp, act);
    endtask

    // voq index from port and class
    function automatic qid_t expected_qid(port_t port, tc_t tc);
        int idx;
        idx = int'(port) * `TMU_TCS + int'(tc);
        return qid_t'(idx);
    endfunction

    function automatic seg_len_t legal_len();
        return seg_len_t'(1 + {$random(seed)} % `TMU_MAX_SEG);
    endfunction

    function automatic bit model_idle();
        bit idle;
        idle = !m_enq.valid && !m_tag.valid && !m_rrq.valid;
        idle = idle && (m_credits == CREDITS) && (unreturned == 0);
        for (int q = 0; q < QUEUES; q++) begin
            idle = idle && (model_q[q].size() == 0);
        end
        return idle;
    endfunction

    task automatic reset_model();
        for (int q = 0; q < QUEUES; q++) begin
            model_q[q].delete();
            m_segs[q] = '0;
        end
        m_enq      = '0;
        m_tag      = '0;
        m_rrq      = '0;
        m_drops    = '0;
        m_bad      = '0;
        m_credits  = CREDITS;
        unreturned = 0;
    endtask

    // inputs read here are the ones the DUT samples at this edge
    task automatic step_model();
        tag_t head;
        // request stage takes last popped tag
        m_rrq      = m_tag;
        m_credits  = m_credits + int'(rrq_credit) - int'(pop);
        unreturned = unreturned + int'(m_rrq.valid) - int'(rrq_credit);
        // head leaves before a same edge enqueue
        m_tag = '0;
        if (pop) begin
            head = model_q[pop_qid].pop_front();
            m_segs[pop_qid] = m_segs[pop_qid] - seg_cnt_t'(head.len);
            m_tag = head;
        end
        // full check after that pop
        if (m_enq.valid) begin
            if (model_q[m_enq.qid].size() < DEPTH) begin
                model_q[m_enq.qid].push_back(m_enq);
                m_segs[m_enq.qid] = m_segs[m_enq.qid] + seg_cnt_t'(m_enq.len);
            end else begin
                m_drops++;
            end
        end
        // collator stage, bad lengths counted
        m_enq = '0;
        if (ring_valid && (ring_len == '0 || int'(ring_len) > `TMU_MAX_SEG)) begin
            m_bad++;
        end else if (ring_valid) begin
            m_enq.valid = 1'b1;
            m_enq.qid   = expected_qid(ring_port, ring_tc);
            m_enq.ptr   = ring_ptr;
            m_enq.len   = ring_len;
        end
    endtask

    // scheduler, random valid queue while credits remain
    task automatic drive_pop();
        int  start;
        int  q;
        bit  found;
        found = 1'b0;
        start = {$random(seed)} % QUEUES;
        pop <= 1'b0;
        for (int i = 0; i < QUEUES; i++) begin
            q = (start + i) % QUEUES;
            if (!found && m_credits > 0 && model_q[q].size() > 0) begin
                found = 1'b1;
                pop <= 1'b1;
                pop_qid <= qid_t'(q);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            step_model();
            drive_pop();
            // credit return after a random delay
            rrq_credit <= !credit_hold && (unreturned > 0) && (($random(seed) & 1) == 0);
        end
        if (rst_n && rrq_valid) rrq_seen++;
    end

    // ----------------------------------------
    // compare, outputs stable at negedge
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            for (int q = 0; q < QUEUES; q++) begin
                check_bit($sformatf("queue_valid[%0d]", q), model_q[q].size() != 0,
                          queue_valid[q]);
                check_segs($sformatf("queue_segs[%0d]", q), m_segs[q], queue_segs[q]);
            end
            check_bit("pop_ready", m_credits != 0, pop_ready);
            // pipeline model fixes pop to request at 2
            check_bit("rrq_valid", m_rrq.valid, rrq_valid);
            if (m_rrq.valid) begin
                check_qid("rrq_qid", m_rrq.qid, rrq_qid);
                check_ptr("rrq_ptr", m_rrq.ptr, rrq_ptr);
                check_len("rrq_len", m_rrq.len, rrq_len);
            end
        end
    end

    task automatic send_tag(port_t port, tc_t tc, buf_ptr_t ptr, seg_len_t len);
        @(posedge clk);
        ring_valid <= 1'b1;
        ring_port  <= port;
        ring_tc    <= tc;
        ring_ptr   <= ptr;
        ring_len   <= len;
    endtask

    task automatic idle_ring();
        @(posedge clk);
        ring_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (!model_idle()) begin
            @(negedge clk);
        end
    endtask

    initial begin
        err_cnt_t base;
        int       seen_base;
        int       bad_sent;
        seg_len_t len;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int q = 0; q < QUEUES; q++) begin
            check_bit("queue_valid after reset", 1'b0, queue_valid[q]);
        end
        check_bit("rrq_valid", 1'b0, rrq_valid);
        check_bit("pop_ready", 1'b1, pop_ready);
        check_count("bad_tag_count", '0, bad_tag_count);
        check_count("drop_count", '0, drop_count);

        // every port and class, queues interleaved
        test_name = "routing";
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < `TMU_PORTS; p++) begin
                for (int t = 0; t < `TMU_TCS; t++) begin
                    send_tag(port_t'(p), tc_t'(t), buf_ptr_t'($random(seed)), legal_len());
                end
            end
        end
        idle_ring();
        wait_drained();

        // full length field range, gaps on the ring
        test_name = "malformed";
        base      = bad_tag_count;
        bad_sent  = 0;
        for (int i = 0; i < MIXED; i++) begin
            len = seg_len_t'($random(seed));
            if (($random(seed) & 3) == 0) begin
                idle_ring();
            end else begin
                if (len == '0 || int'(len) > `TMU_MAX_SEG) bad_sent++;
                send_tag(port_t'($random(seed)), tc_t'($random(seed)),
                         buf_ptr_t'($random(seed)), len);
            end
        end
        idle_ring();
        wait_drained();
        check_count("bad tags counted", err_cnt_t'(bad_sent), bad_tag_count - base);

        // withhold credits, overfill voq 3
        test_name = "credit_hold";
        base      = drop_count;
        seen_base = rrq_seen;
        @(posedge clk);
        credit_hold <= 1'b1;
        repeat (DEPTH + CREDITS + EXTRA) begin
            send_tag(port_t'(1), tc_t'(1), buf_ptr_t'($random(seed)), legal_len());
        end
        idle_ring();
        repeat (8) @(negedge clk);
        check_count("requests under hold", err_cnt_t'(CREDITS), err_cnt_t'(rrq_seen - seen_base));
        check_bit("pop_ready under hold", 1'b0, pop_ready);
        check_count("tags dropped", err_cnt_t'(EXTRA), drop_count - base);

        // held queue drains in order
        test_name = "credit_resume";
        @(posedge clk);
        credit_hold <= 1'b0;
        wait_drained();

        // sparse tags, pop to request spacing
        test_name = "latency";
        for (int i = 0; i < 16; i++) begin
            send_tag(port_t'($random(seed)), tc_t'($random(seed)),
                     buf_ptr_t'($random(seed)), legal_len());
            idle_ring();
            repeat (2) @(posedge clk);
        end
        wait_drained();

        test_name = "final";
        check_count("bad_tag_count", m_bad, bad_tag_count);
        check_count("drop_count", m_drops, drop_count);
        $display("Simulation completed successfully");
        $finish;
    end

    // watchdog, 20 cycles per stimulus cycle plus margin
    initial begin
        #((STIM_CYCLES * 20 + 500) * 10);
        abort_run("Watchdog expired before the test sequence finished");
    end

endmodule : tb_tmu

`default_nettype wire

/* sim.f */
+incdir+include
verilog/tmu_pkg.sv
verilog/tmu_enq_if.sv
verilog/tmu_pop_if.sv
verilog/tag_collate.sv
verilog/tag_queue_bank.sv
verilog/read_requester.sv
verilog/tmu.sv
tests/tb_tmu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_tmu -o tb_tmu_sim \
    && ./obj_dir/tb_tmu_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
